// File: common/zhxpu_pkg.sv
package zhxpu_pkg;

	localparam int WORD_W     = 16;
	localparam int REG_ADDR_W = 3;
	localparam int NUM_REGS   = 1 << REG_ADDR_W;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// major opcode, instruction bits 15..11
	typedef enum logic [4:0] {
		OP_NOP   = 5'b00001,
		OP_ADDIU = 5'b01001,
		OP_LI    = 5'b01101,
		OP_LW    = 5'b10011,
		OP_SW    = 5'b11011,
		OP_ADDU  = 5'b11100,
		OP_AND   = 5'b11101,
		OP_SUBU  = 5'b11110,
		OP_OR    = 5'b11111
	} opcode_t;

	// instruction field positions
	localparam int OP_HI   = 15;
	localparam int OP_LO   = 11;
	localparam int RX_HI   = 10;
	localparam int RX_LO   = 8;
	localparam int RY_HI   = 7;
	localparam int RY_LO   = 5;
	localparam int RZ_HI   = 4;
	localparam int RZ_LO   = 2;
	localparam int IMM8_HI = 7;
	localparam int IMM8_LO = 0;
	localparam int OFF5_HI = 4;
	localparam int OFF5_LO = 0;

endpackage

// File: verilog/fetch.sv
`timescale 1ns/1ns

module fetch import zhxpu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  hold,
	output word_t inst_addr
);

	// word-addressed pc advancing one instruction per cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			inst_addr <= '0;
		end else if (!hold) begin
			inst_addr <= inst_addr + word_t'(1);
		end
	end

endmodule

// File: verilog/if_id.sv
`timescale 1ns/1ns

module if_id import zhxpu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  hold,
	input  word_t pc_in,
	input  word_t inst_in,
	output word_t inst_out,
	output logic  valid
);

	// slot turns valid with the first capture after reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (!hold) begin
			valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			inst_out <= inst_in;
		end
	end

endmodule

// File: verilog/decoder.sv
`timescale 1ns/1ns

module decoder import zhxpu_pkg::*; (
	input  word_t     inst,
	input  logic      valid,
	output opcode_t   op,
	output reg_addr_t read_addr1,
	output reg_addr_t read_addr2,
	output reg_addr_t write_addr,
	output logic      reg_write,
	output word_t     imm
);

	localparam int IMM8_W = IMM8_HI - IMM8_LO + 1;
	localparam int OFF5_W = OFF5_HI - OFF5_LO + 1;

	opcode_t   raw_op;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	word_t     imm8_zext;
	word_t     imm8_sext;
	word_t     off5_sext;

	assign raw_op = opcode_t'(inst[OP_HI:OP_LO]);
	assign rx     = inst[RX_HI:RX_LO];
	assign ry     = inst[RY_HI:RY_LO];
	assign rz     = inst[RZ_HI:RZ_LO];

	assign imm8_zext = {{(WORD_W-IMM8_W){1'b0}}, inst[IMM8_HI:IMM8_LO]};
	assign imm8_sext = {{(WORD_W-IMM8_W){inst[IMM8_HI]}}, inst[IMM8_HI:IMM8_LO]};
	assign off5_sext = {{(WORD_W-OFF5_W){inst[OFF5_HI]}}, inst[OFF5_HI:OFF5_LO]};

	// rx is always the first operand (or base), ry the second (or store data)
	assign read_addr1 = rx;
	assign read_addr2 = ry;

	always_comb begin
		op         = OP_NOP;
		write_addr = '0;
		reg_write  = 1'b0;
		imm        = '0;
		if (valid) begin
			case (raw_op)
				OP_LI: begin
					op         = OP_LI;
					write_addr = rx;
					reg_write  = 1'b1;
					imm        = imm8_zext;
				end
				OP_ADDIU: begin
					op         = OP_ADDIU;
					write_addr = rx;
					reg_write  = 1'b1;
					imm        = imm8_sext;
				end
				OP_ADDU, OP_SUBU, OP_AND, OP_OR: begin
					op         = raw_op;
					write_addr = rz;
					reg_write  = 1'b1;
				end
				OP_LW: begin
					op         = OP_LW;
					write_addr = ry;
					reg_write  = 1'b1;
					imm        = off5_sext;
				end
				OP_SW: begin
					op  = OP_SW;
					imm = off5_sext;
				end
				// unknown codes fall through as nop
				default: ;
			endcase
		end
	end

endmodule

// File: verilog/register.sv
`timescale 1ns/1ns

module register import zhxpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      wb_en,
	input  reg_addr_t wb_addr,
	input  word_t     wb_value,
	input  reg_addr_t read_addr1,
	input  reg_addr_t read_addr2,
	output word_t     read_value1,
	output word_t     read_value2
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_addr] <= wb_value;
		end
	end

	// write-through, so decode sees the result retiring this cycle
	assign read_value1 = (wb_en && wb_addr == read_addr1) ? wb_value : regs[read_addr1];
	assign read_value2 = (wb_en && wb_addr == read_addr2) ? wb_value : regs[read_addr2];

endmodule

// File: verilog/id_exe.sv
`timescale 1ns/1ns

module id_exe import zhxpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      hold,
	input  opcode_t   op_in,
	input  reg_addr_t write_addr_in,
	input  logic      reg_write_in,
	input  word_t     imm_in,
	input  word_t     op1_in,
	input  word_t     op2_in,
	output opcode_t   op_out,
	output reg_addr_t write_addr_out,
	output logic      reg_write_out,
	output word_t     imm_out,
	output word_t     op1_out,
	output word_t     op2_out
);

	// an empty slot is a nop with no write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_out        <= OP_NOP;
			reg_write_out <= 1'b0;
		end else if (!hold) begin
			op_out        <= op_in;
			reg_write_out <= reg_write_in;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			write_addr_out <= write_addr_in;
			imm_out        <= imm_in;
			op1_out        <= op1_in;
			op2_out        <= op2_in;
		end
	end

endmodule

// File: verilog/exe_stage.sv
`timescale 1ns/1ns

module exe_stage import zhxpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  opcode_t   op,
	input  reg_addr_t write_addr,
	input  logic      reg_write,
	input  word_t     imm,
	input  word_t     op1,
	input  word_t     op2,
	input  logic      mem_done,
	input  word_t     mem_rdata,
	output logic      hold,
	output logic      mem_req,
	output logic      mem_we,
	output word_t     mem_addr,
	output word_t     mem_wdata,
	output logic      wb_en,
	output reg_addr_t wb_addr,
	output word_t     wb_value
);

	logic  is_mem;
	logic  done_q;
	word_t sum_imm;
	word_t alu_res;

	assign is_mem  = (op == OP_LW) || (op == OP_SW);
	assign sum_imm = op1 + imm;

	always_comb begin
		case (op)
			OP_LI:    alu_res = imm;
			OP_ADDIU: alu_res = sum_imm;
			OP_ADDU:  alu_res = op1 + op2;
			OP_SUBU:  alu_res = op1 - op2;
			OP_AND:   alu_res = op1 & op2;
			OP_OR:    alu_res = op1 | op2;
			default:  alu_res = '0;
		endcase
	end

	// set for the one cycle after mem_done, while the finished op
	// still sits in execute and must not request again
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done_q <= 1'b0;
		end else begin
			done_q <= mem_done;
		end
	end

	assign mem_req   = is_mem && !done_q;
	assign mem_we    = mem_req && (op == OP_SW);
	assign mem_addr  = sum_imm;
	assign mem_wdata = op2;

	// the whole pipeline waits out the request, done cycle included
	assign hold = mem_req;

	// loads retire in the done cycle, everything else right away
	assign wb_en    = reg_write && ((op == OP_LW) ? mem_done : 1'b1);
	assign wb_addr  = write_addr;
	assign wb_value = (op == OP_LW) ? mem_rdata : alu_res;

endmodule

// File: verilog/zhxpu.sv
`timescale 1ns/1ns

module zhxpu import zhxpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  word_t     inst_data,
	input  logic      mem_done,
	input  word_t     mem_rdata,
	output word_t     inst_addr,
	output logic      mem_req,
	output logic      mem_we,
	output word_t     mem_addr,
	output word_t     mem_wdata,
	output logic      wb_en,
	output reg_addr_t wb_addr,
	output word_t     wb_value
);

	logic      hold;

	word_t     id_inst;
	logic      id_valid;
	opcode_t   id_op;
	reg_addr_t id_read_addr1;
	reg_addr_t id_read_addr2;
	reg_addr_t id_write_addr;
	logic      id_reg_write;
	word_t     id_imm;
	word_t     id_read_value1;
	word_t     id_read_value2;

	opcode_t   exe_op;
	reg_addr_t exe_write_addr;
	logic      exe_reg_write;
	word_t     exe_imm;
	word_t     exe_op1;
	word_t     exe_op2;

	// IF stage
	fetch __fetch(
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.inst_addr(inst_addr)
	);

	if_id __if_id(
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.pc_in(inst_addr),
		.inst_in(inst_data),
		.inst_out(id_inst),
		.valid(id_valid)
	);

	// ID stage
	decoder __decoder(
		.inst(id_inst),
		.valid(id_valid),
		.op(id_op),
		.read_addr1(id_read_addr1),
		.read_addr2(id_read_addr2),
		.write_addr(id_write_addr),
		.reg_write(id_reg_write),
		.imm(id_imm)
	);

	register __register(
		.clk(clk),
		.rst_n(rst_n),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_value(wb_value),
		.read_addr1(id_read_addr1),
		.read_addr2(id_read_addr2),
		.read_value1(id_read_value1),
		.read_value2(id_read_value2)
	);

	id_exe __id_exe(
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.op_in(id_op),
		.write_addr_in(id_write_addr),
		.reg_write_in(id_reg_write),
		.imm_in(id_imm),
		.op1_in(id_read_value1),
		.op2_in(id_read_value2),
		.op_out(exe_op),
		.write_addr_out(exe_write_addr),
		.reg_write_out(exe_reg_write),
		.imm_out(exe_imm),
		.op1_out(exe_op1),
		.op2_out(exe_op2)
	);

	// EXE and write-back
	exe_stage __exe_stage(
		.clk(clk),
		.rst_n(rst_n),
		.op(exe_op),
		.write_addr(exe_write_addr),
		.reg_write(exe_reg_write),
		.imm(exe_imm),
		.op1(exe_op1),
		.op2(exe_op2),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.hold(hold),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_value(wb_value)
	);

endmodule

// File: verif/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
	output logic clk,
	output logic por_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// power-on reset, released just after the fourth rising edge
	initial begin
		por_n = 1'b0;
		repeat (4) @(posedge clk);
		#2 por_n = 1'b1;
	end

endmodule

// File: verif/zhxpu_chk.sv
`timescale 1ns/1ns

module zhxpu_chk (
	input logic        clk,
	input logic        rst_n,
	input logic        mem_req,
	input logic        mem_we,
	input logic        mem_done,
	input logic [15:0] mem_addr,
	input logic [15:0] mem_wdata,
	input logic        wb_en
);

	// high when the previous edge saw reset
	logic reset_q;

	always_ff @(posedge clk) begin
		reset_q <= !rst_n;
	end

	// request fields stay put until the access completes
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && !mem_done |=> mem_req && $stable(mem_we) && $stable(mem_addr)
			&& $stable(mem_wdata))
		else $error("memory request changed before mem_done");

	assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> mem_req)
		else $error("mem_we high without mem_req");

	assert property (@(posedge clk) !rst_n && reset_q |-> !wb_en && !mem_req)
		else $error("wb_en or mem_req active during reset");

endmodule

bind zhxpu zhxpu_chk chk (
	.clk(clk),
	.rst_n(rst_n),
	.mem_req(mem_req),
	.mem_we(mem_we),
	.mem_done(mem_done),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.wb_en(wb_en)
);

// File: verif/tb_zhxpu.sv
`timescale 1ns/1ns

module tb_zhxpu import zhxpu_pkg::*; ();

	localparam int PROG_LEN  = 64;
	localparam int NUM_TESTS = 5;
	localparam int MAX_CYCLES = 6 * PROG_LEN * NUM_TESTS + 100;

	logic      clk;
	logic      por_n;
	logic      tb_rst_n;
	logic      rst_n;
	word_t     inst_data;
	logic      mem_done;
	word_t     mem_rdata;
	word_t     inst_addr;
	logic      mem_req;
	logic      mem_we;
	word_t     mem_addr;
	word_t     mem_wdata;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_value;

	logic [31:0] rng_state = 32'h360c0659;
	word_t       prog [PROG_LEN];
	word_t       data_mem [256];
	word_t       model_mem [256];
	word_t       model_regs [NUM_REGS];
	logic [18:0] exp_wb [$];
	logic [31:0] exp_st [$];
	reg_addr_t   prev_rz;
	int          errors = 0;
	int          checks = 0;
	int          wb_seen;
	int          cycles = 0;
	logic        mem_busy;
	int          mem_wait;

	assign rst_n = por_n & tb_rst_n;

	clk_gen clocks (
		.clk(clk),
		.por_n(por_n)
	);

	zhxpu DUT (
		.clk(clk),
		.rst_n(rst_n),
		.inst_data(inst_data),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.inst_addr(inst_addr),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_value(wb_value)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic word_t encode(input opcode_t op, input reg_addr_t rx,
			input reg_addr_t ry, input reg_addr_t rz, input logic [7:0] imm8);
		word_t w;
		w = '0;
		w[OP_HI:OP_LO] = op;
		if (op != OP_NOP) begin
			w[RX_HI:RX_LO] = rx;
		end
		if (op == OP_LI || op == OP_ADDIU) begin
			w[IMM8_HI:IMM8_LO] = imm8;
		end else if (op == OP_LW || op == OP_SW) begin
			w[RY_HI:RY_LO] = ry;
			w[OFF5_HI:OFF5_LO] = imm8[4:0];
		end else if (op != OP_NOP) begin
			w[RY_HI:RY_LO] = ry;
			w[RZ_HI:RZ_LO] = rz;
		end
		return w;
	endfunction

	function automatic opcode_t pick_alu(input logic [1:0] s);
		case (s)
			2'd0:    return OP_ADDU;
			2'd1:    return OP_SUBU;
			2'd2:    return OP_AND;
			default: return OP_OR;
		endcase
	endfunction

	function automatic opcode_t pick_any(input logic [7:0] s);
		opcode_t ops [9];
		ops = '{OP_NOP, OP_LI, OP_ADDIU, OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_LW, OP_SW};
		return ops[32'(s) % 9];
	endfunction

	task automatic gen_program(input int kind);
		logic [31:0] r;
		opcode_t     op;
		for (int i = 0; i < PROG_LEN; i++) begin
			r = next_rand();
			if (kind > 1 && kind < 5 && i < 8) begin
				// preload every register with a random value
				op = OP_LI;
				r[2:0] = 3'(i);
			end else begin
				case (kind)
					1: op = r[31] ? OP_ADDIU : OP_LI;
					2: op = pick_alu(r[31:30]);
					3: op = (i % 2 == 0) ? OP_SW : (r[31] ? OP_ADDIU : OP_LI);
					4: op = (r[31:30] == 2'd0) ? OP_ADDIU :
						(r[31] ? OP_LW : pick_alu(r[29:28]));
					default: op = pick_any(r[31:24]);
				endcase
			end
			// chained alu ops take the previous result as first operand
			if (kind == 2 && i >= 8) begin
				r[2:0] = prev_rz;
			end
			prog[i] = encode(op, r[2:0], r[5:3], r[8:6], r[16:9]);
			prev_rz = r[8:6];
		end
	endtask

	task automatic model_write(input reg_addr_t r, input word_t v);
		model_regs[r] = v;
		exp_wb.push_back({r, v});
	endtask

	task automatic model_step(input word_t inst);
		logic [4:0] op;
		reg_addr_t  rx;
		reg_addr_t  ry;
		reg_addr_t  rz;
		logic [7:0] imm8;
		word_t      a;
		word_t      b;
		word_t      addr;
		op   = inst[OP_HI:OP_LO];
		rx   = inst[RX_HI:RX_LO];
		ry   = inst[RY_HI:RY_LO];
		rz   = inst[RZ_HI:RZ_LO];
		imm8 = inst[IMM8_HI:IMM8_LO];
		a    = model_regs[rx];
		b    = model_regs[ry];
		addr = a + {{11{inst[OFF5_HI]}}, inst[OFF5_HI:OFF5_LO]};
		case (op)
			OP_LI:    model_write(rx, {8'h00, imm8});
			OP_ADDIU: model_write(rx, a + {{8{imm8[7]}}, imm8});
			OP_ADDU:  model_write(rz, a + b);
			OP_SUBU:  model_write(rz, a - b);
			OP_AND:   model_write(rz, a & b);
			OP_OR:    model_write(rz, a | b);
			OP_LW:    model_write(ry, model_mem[addr[7:0]]);
			OP_SW: begin
				exp_st.push_back({addr, b});
				model_mem[addr[7:0]] = b;
			end
			default: ;
		endcase
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// instruction memory answers the current address
	always @(posedge clk) begin
		#2;
		inst_data = (32'(inst_addr) < PROG_LEN) ? prog[inst_addr[5:0]] : encode(OP_NOP, 3'd0,
			3'd0, 3'd0, 8'h00);
	end

	// data memory with 0 to 4 cycles of latency
	always @(posedge clk) begin
		#2;
		if (!rst_n || mem_done) begin
			mem_done = 1'b0;
			mem_busy = 1'b0;
		end else if (mem_req) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				mem_wait = int'(next_rand() % 32'd5);
			end
			if (mem_wait == 0) begin
				if (mem_we) begin
					data_mem[mem_addr[7:0]] = mem_wdata;
				end else begin
					mem_rdata = data_mem[mem_addr[7:0]];
				end
				mem_done = 1'b1;
			end else begin
				mem_wait--;
			end
		end
	end

	// results are sampled mid-cycle
	always @(negedge clk) begin
		logic [18:0] e;
		logic [31:0] s;
		if (rst_n) begin
			if (wb_en) begin
				if (exp_wb.size() == 0) begin
					errors++;
					$display("write-back to r%0d at %0t was not expected", wb_addr, $time);
				end else begin
					e = exp_wb.pop_front();
					check("wb_addr", 32'(wb_addr), 32'(e[18:16]));
					check("wb_value", 32'(wb_value), 32'(e[15:0]));
					wb_seen++;
				end
			end
			if (mem_req && mem_we && mem_done) begin
				if (exp_st.size() == 0) begin
					errors++;
					$display("store to %h at %0t was not expected", mem_addr, $time);
				end else begin
					s = exp_st.pop_front();
					check("mem_addr", 32'(mem_addr), 32'(s[31:16]));
					check("mem_wdata", 32'(mem_wdata), 32'(s[15:0]));
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic run_test(input int kind, input string name);
		int          err0;
		int          wb_total;
		int          st_total;
		logic [31:0] r;
		err0 = errors;
		@(posedge clk);
		#2 tb_rst_n = 1'b0;
		gen_program(kind);
		for (int i = 0; i < 256; i++) begin
			r = next_rand();
			data_mem[i]  = r[15:0];
			model_mem[i] = r[15:0];
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		exp_wb.delete();
		exp_st.delete();
		for (int i = 0; i < PROG_LEN; i++) begin
			model_step(prog[i]);
		end
		wb_total = exp_wb.size();
		st_total = exp_st.size();
		wb_seen  = 0;
		repeat (4) @(posedge clk);
		#2 tb_rst_n = 1'b1;
		while (32'(inst_addr) < PROG_LEN + 3) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		check("write-back count", 32'(wb_seen), 32'(wb_total));
		if (exp_st.size() != 0) begin
			errors++;
			$display("%0d expected stores never appeared", exp_st.size());
		end
		$display("test %0d %s: %0d write-backs, %0d stores, %s", kind, name, wb_total,
			st_total, (errors == err0) ? "ok" : "mismatch");
	endtask

	initial begin
		tb_rst_n  = 1'b0;
		inst_data = '0;
		mem_done  = 1'b0;
		mem_rdata = '0;
		mem_busy  = 1'b0;
		mem_wait  = 0;
		prev_rz   = '0;
		@(posedge por_n);
		run_test(1, "immediates");
		run_test(2, "alu chain");
		run_test(3, "stores");
		run_test(4, "loads");
		run_test(5, "mixed");
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: zhxpu.f
common/zhxpu_pkg.sv
verilog/fetch.sv
verilog/if_id.sv
verilog/decoder.sv
verilog/register.sv
verilog/id_exe.sv
verilog/exe_stage.sv
verilog/zhxpu.sv
verif/clk_gen.sv
verif/zhxpu_chk.sv
verif/tb_zhxpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f zhxpu.f --top-module tb_zhxpu -o sim_zhxpu
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_zhxpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
